/* dnc_settings.svh */
// DNC write stage settings
// Word format, location count and sigmoid segment limits, all Q4.12

`ifndef DNC_SETTINGS_SVH
`define DNC_SETTINGS_SVH

// Word width in bits
`define DNC_DATA_SIZE 16

// Fraction bits of the Q4.12 format
`define DNC_FRAC_BITS 12

// Number of memory locations N
`define DNC_LOCATIONS 4

// Sigmoid segment limits on the logit magnitude
// 1.0
`define DNC_BREAK_LOW  16'd4096
// 2.375
`define DNC_BREAK_MID  16'd9728
// 5.0, saturation point
`define DNC_BREAK_HIGH 16'd20480

`endif

/* dnc_pkg.sv */
// DNC write stage types
// Fixed-point word, probability and weighting vector shared by all blocks

`include "dnc_settings.svh"

package dnc_pkg;

  //////////////////////////////
  // Scalars
  //////////////////////////////

  // Signed Q4.12 logit or weighting element
  typedef logic signed [`DNC_DATA_SIZE-1:0] dnc_word_t;

  // Unsigned Q4.12, zero to one
  typedef logic [`DNC_DATA_SIZE-1:0] dnc_prob_t;

  // One in Q4.12
  localparam dnc_prob_t DNC_ONE = dnc_prob_t'(1 << `DNC_FRAC_BITS);

  //////////////////////////////
  // Vectors
  //////////////////////////////

  // One probability per memory location
  typedef dnc_prob_t [`DNC_LOCATIONS-1:0] dnc_weighting_t;

endpackage

/* logistic_if.sv */
// Logistic link
// Joins a gate block to its scalar sigmoid unit

`timescale 1ns/1ps

interface logistic_if import dnc_pkg::*; ();

  // One-cycle request pulse, data_in valid with it
  logic      start;
  dnc_word_t data_in;

  // One-cycle result pulse, data_out valid with it
  logic      ready;
  dnc_prob_t data_out;

  // Gate side
  modport client (
    output start,
    output data_in,
    input  ready,
    input  data_out
  );

  // Sigmoid unit side
  modport unit (
    input  start,
    input  data_in,
    output ready,
    output data_out
  );

endinterface

/* ntm_scalar_logistic_function.sv */
// Scalar logistic unit
// Piecewise-linear sigmoid of a Q4.12 logit, four segments with
// power-of-two slopes, mirrored for negative inputs
// Pipeline of magnitude, segment and mirror stages, result 3 cycles on

`timescale 1ns/1ps

`include "dnc_settings.svh"

module ntm_scalar_logistic_function import dnc_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  logistic_if.unit lg
);

  localparam int W = `DNC_DATA_SIZE;
  localparam int F = `DNC_FRAC_BITS;

  // Segment offsets 0.5, 0.625 and 0.84375
  localparam dnc_prob_t OFS_LOW  = dnc_prob_t'(1 << (F - 1));
  localparam dnc_prob_t OFS_MID  = dnc_prob_t'(5 << (F - 3));
  localparam dnc_prob_t OFS_HIGH = dnc_prob_t'(27 << (F - 5));

  localparam dnc_prob_t BRK_LOW  = `DNC_BREAK_LOW;
  localparam dnc_prob_t BRK_MID  = `DNC_BREAK_MID;
  localparam dnc_prob_t BRK_HIGH = `DNC_BREAK_HIGH;

  logic      busy;
  logic      accept;

  // Stage 1, magnitude
  logic      s1_valid;
  logic      s1_neg;
  dnc_prob_t s1_mag;
  dnc_prob_t mag_c;

  // Stage 2, segment value
  logic      s2_valid;
  logic      s2_neg;
  dnc_prob_t s2_val;
  dnc_prob_t seg_c;

  // Requests while busy are dropped
  assign accept = lg.start & ~busy;

  // Absolute value, -8.0 maps to 32768 unsigned
  always_comb begin
    if (lg.data_in[W-1]) begin
      mag_c = dnc_prob_t'(-lg.data_in);
    end else begin
      mag_c = dnc_prob_t'(lg.data_in);
    end
  end

  // Segment select, shifts truncate
  always_comb begin
    if (s1_mag >= BRK_HIGH) begin
      seg_c = DNC_ONE;
    end else if (s1_mag >= BRK_MID) begin
      seg_c = (s1_mag >> 5) + OFS_HIGH;
    end else if (s1_mag >= BRK_LOW) begin
      seg_c = (s1_mag >> 3) + OFS_MID;
    end else begin
      seg_c = (s1_mag >> 2) + OFS_LOW;
    end
  end

  //////////////////////////////
  // Control and result
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy        <= 1'b0;
      s1_valid    <= 1'b0;
      s2_valid    <= 1'b0;
      lg.ready    <= 1'b0;
      lg.data_out <= '0;
    end else begin
      s1_valid <= accept;
      s2_valid <= s1_valid;
      lg.ready <= s2_valid;
      if (accept) begin
        busy <= 1'b1;
      end else if (s2_valid) begin
        busy <= 1'b0;
      end
      // Mirror stage, sigmoid(-x) = 1 - sigmoid(x)
      if (s2_valid) begin
        lg.data_out <= s2_neg ? DNC_ONE - s2_val : s2_val;
      end
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_mag <= mag_c;
      s1_neg <= lg.data_in[W-1];
    end
    if (s1_valid) begin
      s2_val <= seg_c;
      s2_neg <= s1_neg;
    end
  end

endmodule

/* dnc_write_gate.sv */
// DNC write gate
// gw = sigmoid(write-gate logit), held until the next start
// Ready pulses 4 cycles after an accepted start

`timescale 1ns/1ps

module dnc_write_gate import dnc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  dnc_word_t gw_in,
  output logic      ready,
  output dnc_prob_t gw_out
);

  // Computation in flight
  logic busy;

  logistic_if lg_if ();

  //////////////////////////////
  // Sigmoid request
  //////////////////////////////

  // Start only reaches the unit when idle
  assign lg_if.start   = start & ~busy;
  assign lg_if.data_in = gw_in;

  ntm_scalar_logistic_function u_logistic (
    .clk   (clk),
    .rst_n (rst_n),
    .lg    (lg_if)
  );

  //////////////////////////////
  // Result register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      ready  <= 1'b0;
      gw_out <= '0;
    end else begin
      // Ready follows the unit by one cycle
      ready <= lg_if.ready;
      if (lg_if.start) begin
        busy <= 1'b1;
      end else if (lg_if.ready) begin
        busy <= 1'b0;
      end
      if (lg_if.ready) begin
        gw_out <= lg_if.data_out;
      end
    end
  end

endmodule

/* dnc_allocation_gate.sv */
// DNC allocation gate
// ga = sigmoid(allocation-gate logit) and its complement 1 - ga,
// both held until the next start
// Ready pulses 4 cycles after an accepted start

`timescale 1ns/1ps

module dnc_allocation_gate import dnc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  dnc_word_t ga_in,
  output logic      ready,
  output dnc_prob_t ga_out,
  output dnc_prob_t ga_comp
);

  // Computation in flight
  logic busy;

  logistic_if lg_if ();

  //////////////////////////////
  // Sigmoid request
  //////////////////////////////

  // Dropped while a value is being computed
  assign lg_if.start   = start & ~busy;
  assign lg_if.data_in = ga_in;

  ntm_scalar_logistic_function u_logistic (
    .clk   (clk),
    .rst_n (rst_n),
    .lg    (lg_if)
  );

  //////////////////////////////
  // Gate and complement
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      ready   <= 1'b0;
      ga_out  <= '0;
      ga_comp <= '0;
    end else begin
      ready <= lg_if.ready;
      if (lg_if.start) begin
        busy <= 1'b1;
      end else if (lg_if.ready) begin
        busy <= 1'b0;
      end
      // Complement registered alongside, weighting needs no subtractor
      if (lg_if.ready) begin
        ga_out  <= lg_if.data_out;
        ga_comp <= DNC_ONE - lg_if.data_out;
      end
    end
  end

endmodule

/* dnc_write_weighting.sv */
// DNC write weighting
// w[i] = gw * (ga * a[i] + (1 - ga) * c[i]), Q4.12, truncating shifts
// Waits for both gates, then one location per cycle over N cycles

`timescale 1ns/1ps

`include "dnc_settings.svh"

module dnc_write_weighting import dnc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  dnc_prob_t      gw,
  input  logic           gw_ready,
  input  dnc_prob_t      ga,
  input  dnc_prob_t      ga_comp,
  input  logic           ga_ready,
  input  dnc_weighting_t alloc_weighting,
  input  dnc_weighting_t content_weighting,
  output logic           ready,
  output dnc_weighting_t write_weighting
);

  localparam int W  = `DNC_DATA_SIZE;
  localparam int F  = `DNC_FRAC_BITS;
  localparam int N  = `DNC_LOCATIONS;
  localparam int CW = (N > 1) ? $clog2(N) : 1;

  localparam logic [CW-1:0] LAST = CW'(N - 1);

  logic          busy;
  logic [CW-1:0] cnt;

  // Gate arrival, either order
  logic gw_seen;
  logic ga_seen;
  logic gw_have;
  logic ga_have;

  // Per-location arithmetic
  logic [2*W:0]   mix_sum;
  logic [2*W-F:0] mix_q;
  logic [3*W-F:0] scaled;
  dnc_prob_t      slot_c;

  assign gw_have = gw_ready | gw_seen;
  assign ga_have = ga_ready | ga_seen;

  //////////////////////////////
  // Location datapath
  //////////////////////////////

  always_comb begin
    // Blend of allocation and content, products widened before the add
    mix_sum = ga * alloc_weighting[cnt] + ga_comp * content_weighting[cnt];
    mix_q   = mix_sum[2*W:F];
    // Scale by the write gate
    scaled  = mix_q * gw;
    slot_c  = scaled[F +: W];
  end

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy            <= 1'b0;
      cnt             <= '0;
      gw_seen         <= 1'b0;
      ga_seen         <= 1'b0;
      ready           <= 1'b0;
      write_weighting <= '0;
    end else begin
      ready <= 1'b0;
      if (!busy) begin
        if (gw_have && ga_have) begin
          // Both gates in, walk from location 0
          busy    <= 1'b1;
          cnt     <= '0;
          gw_seen <= 1'b0;
          ga_seen <= 1'b0;
        end else begin
          gw_seen <= gw_have;
          ga_seen <= ga_have;
        end
      end else begin
        write_weighting[cnt] <= slot_c;
        // Last location, result complete
        if (cnt == LAST) begin
          busy  <= 1'b0;
          ready <= 1'b1;
          cnt   <= '0;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* dnc_write_unit.sv */
// DNC write unit
// Top of the write-weighting stage: both gates, then the weighting
// Ready pulses 9 cycles after an accepted start, result held after

`timescale 1ns/1ps

module dnc_write_unit import dnc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  dnc_word_t      gw_logit,
  input  dnc_word_t      ga_logit,
  input  dnc_weighting_t alloc_weighting,
  input  dnc_weighting_t content_weighting,
  output logic           ready,
  output dnc_weighting_t write_weighting
);

  logic           busy;
  logic           accept;

  // Gate results
  dnc_prob_t      gw;
  logic           gw_ready;
  dnc_prob_t      ga;
  dnc_prob_t      ga_comp;
  logic           ga_ready;

  // Captured weighting vectors
  dnc_weighting_t alloc_q;
  dnc_weighting_t content_q;

  // New request once idle, or in the cycle the last result is ready
  assign accept = start & (~busy | ready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end else if (ready) begin
      busy <= 1'b0;
    end
  end

  // Caller may change the vectors after start
  always_ff @(posedge clk) begin
    if (accept) begin
      alloc_q   <= alloc_weighting;
      content_q <= content_weighting;
    end
  end

  //////////////////////////////
  // Gates
  //////////////////////////////

  dnc_write_gate u_write_gate (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (accept),
    .gw_in  (gw_logit),
    .ready  (gw_ready),
    .gw_out (gw)
  );

  dnc_allocation_gate u_allocation_gate (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (accept),
    .ga_in   (ga_logit),
    .ready   (ga_ready),
    .ga_out  (ga),
    .ga_comp (ga_comp)
  );

  //////////////////////////////
  // Weighting
  //////////////////////////////

  dnc_write_weighting u_write_weighting (
    .clk               (clk),
    .rst_n             (rst_n),
    .gw                (gw),
    .gw_ready          (gw_ready),
    .ga                (ga),
    .ga_comp           (ga_comp),
    .ga_ready          (ga_ready),
    .alloc_weighting   (alloc_q),
    .content_weighting (content_q),
    .ready             (ready),
    .write_weighting   (write_weighting)
  );

endmodule

/* tb_dnc_write_unit.sv */
// DNC write unit testbench
// LFSR stimulus checked against a model of the sigmoid segments and the
// write weighting, plus latency, dropped starts and input capture

`timescale 1ns/1ps

`include "dnc_settings.svh"

module tb_dnc_write_unit import dnc_pkg::*; ();

  localparam int F              = `DNC_FRAC_BITS;
  localparam int N              = `DNC_LOCATIONS;
  localparam int ONE            = 1 << F;
  localparam int LATENCY        = 9;
  localparam int WAIT_LIMIT     = 30;
  localparam int NUM_REQ        = 200 + 30 + 12 + 1 + 4;
  localparam int TIMEOUT_CYCLES = NUM_REQ * 20 + 100;

  logic           clk;
  logic           rst_n;
  logic           start;
  dnc_word_t      gw_logit;
  dnc_word_t      ga_logit;
  dnc_weighting_t alloc_weighting;
  dnc_weighting_t content_weighting;
  logic           ready;
  dnc_weighting_t write_weighting;

  logic [31:0] lfsr_state = 32'h1da45a7d;
  int          cycle_count = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          req_count   = 0;
  int          test_count  = 0;
  int          test_base   = 0;

  // Segment edges, zero and the ends of the Q4.12 range
  int edge_logits [15] = '{0, 4095, 4096, 9727, 9728, 20479, 20480, 32767,
                           -4095, -4096, -9727, -9728, -20479, -20480, -32768};

  dnc_write_unit u_dnc_write_unit (
    .clk               (clk),
    .rst_n             (rst_n),
    .start             (start),
    .gw_logit          (gw_logit),
    .ga_logit          (ga_logit),
    .alloc_weighting   (alloc_weighting),
    .content_weighting (content_weighting),
    .ready             (ready),
    .write_weighting   (write_weighting)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit from the request count
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // Random numbers
  //////////////////////////////

  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    int          k;
    logic [31:0] r;
    r = '0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic dnc_word_t random_logit();
    dnc_word_t x;
    x = dnc_word_t'(random_bits(16));
    // Half the draws pulled into the sloped segments
    if (random_bits(1) == 32'd1) begin
      x = x >>> 2;
    end
    return x;
  endfunction

  // Elements in 0 to one
  function automatic dnc_weighting_t random_weighting();
    int             i;
    int             v;
    dnc_weighting_t w;
    for (i = 0; i < N; i++) begin
      v = int'(random_bits(13));
      if (v > ONE) begin
        v = v - ONE;
      end
      w[i] = dnc_prob_t'(v);
    end
    return w;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Four segments with slopes 1/4, 1/8, 1/32, then flat at one
  function automatic int sigmoid_model(input dnc_word_t x);
    int xi;
    int mag;
    int val;
    xi  = x;
    mag = (xi < 0) ? -xi : xi;
    if (mag >= int'(`DNC_BREAK_HIGH)) begin
      val = ONE;
    end else if (mag >= int'(`DNC_BREAK_MID)) begin
      val = (mag >> 5) + (27 * ONE) / 32;
    end else if (mag >= int'(`DNC_BREAK_LOW)) begin
      val = (mag >> 3) + (5 * ONE) / 8;
    end else begin
      val = (mag >> 2) + ONE / 2;
    end
    // Negative logits mirror around one half
    if (xi < 0) begin
      val = ONE - val;
    end
    return val;
  endfunction

  function automatic dnc_weighting_t weighting_model(input dnc_word_t gwl,
      input dnc_word_t gal, input dnc_weighting_t a, input dnc_weighting_t c);
    int             i;
    longint         gw;
    longint         ga;
    longint         mix;
    longint         scaled;
    dnc_weighting_t w;
    gw = sigmoid_model(gwl);
    ga = sigmoid_model(gal);
    for (i = 0; i < N; i++) begin
      mix    = (ga * longint'(a[i]) + (ONE - ga) * longint'(c[i])) >>> F;
      scaled = (mix * gw) >>> F;
      w[i]   = dnc_prob_t'(scaled);
    end
    return w;
  endfunction

  //////////////////////////////
  // Checks and requests
  //////////////////////////////

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t: %s expected %0h actual %0h",
               $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("Test %0d %s finished with %0d errors", test_count, name,
             error_count - test_base);
    test_base = error_count;
  endtask

  // busy_at adds a second start with other inputs and scramble changes the vectors
  task automatic run_request(input dnc_word_t gwl, input dnc_word_t gal,
                             input dnc_weighting_t a, input dnc_weighting_t c,
                             input int busy_at, input bit scramble);
    int             i;
    int             n;
    int             lat;
    dnc_weighting_t expected;
    expected = weighting_model(gwl, gal, a, c);
    @(posedge clk);
    gw_logit          <= gwl;
    ga_logit          <= gal;
    alloc_weighting   <= a;
    content_weighting <= c;
    start             <= 1'b1;
    n   = 0;
    lat = 0;
    while (lat == 0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
      start <= (n == busy_at);
      if (n == busy_at) begin
        gw_logit          <= ~gwl;
        ga_logit          <= ~gal;
        alloc_weighting   <= ~a;
        content_weighting <= ~c;
      end
      if (scramble && n == 1) begin
        alloc_weighting   <= random_weighting();
        content_weighting <= random_weighting();
      end
      @(negedge clk);
      if (ready) begin
        lat = n;
      end
    end
    req_count++;
    if (lat == 0) begin
      $display("ERROR at %0t: no ready within %0d cycles of start", $time, WAIT_LIMIT);
      error_count++;
    end else begin
      check_value("ready latency", LATENCY, lat);
      for (i = 0; i < N; i++) begin
        check_value($sformatf("write_weighting[%0d]", i), expected[i], write_weighting[i]);
      end
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int             k;
    dnc_word_t      x;
    dnc_weighting_t all_one;
    dnc_weighting_t held;
    dnc_weighting_t a;
    dnc_weighting_t c;
    rst_n             = 1'b0;
    start             = 1'b0;
    gw_logit          = '0;
    ga_logit          = '0;
    alloc_weighting   = '0;
    content_weighting = '0;
    all_one           = {N{DNC_ONE}};
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("ready", 0, ready);
    check_value("write_weighting", 0, write_weighting);
    report_test("reset");

    repeat (200) begin
      run_request(random_logit(), random_logit(), random_weighting(),
                  random_weighting(), 0, 1'b0);
    end
    report_test("random requests");

    // Each gate seen alone with the other at one and a flat vector
    for (k = 0; k < 15; k++) begin
      x = dnc_word_t'(edge_logits[k]);
      run_request(x, 16'sh7fff, all_one, '0, 0, 1'b0);
      if (edge_logits[k] >= int'(`DNC_BREAK_HIGH)) begin
        check_value("saturated gw", ONE, write_weighting[0]);
      end else if (edge_logits[k] <= -int'(`DNC_BREAK_HIGH)) begin
        check_value("mirrored saturated gw", 0, write_weighting[0]);
      end
      run_request(16'sh7fff, x, all_one, '0, 0, 1'b0);
    end
    report_test("segment edges");

    repeat (4) begin
      a = random_weighting();
      c = random_weighting();
      x = random_logit();
      // Allocation only, content only, then a closed write gate
      run_request(x, 16'sh7fff, a, c, 0, 1'b0);
      run_request(x, dnc_word_t'(16'h8000), a, c, 0, 1'b0);
      run_request(dnc_word_t'(16'h8000), random_logit(), a, c, 0, 1'b0);
      check_value("write_weighting closed gate", 0, write_weighting);
    end
    report_test("gate extremes");

    run_request(random_logit(), random_logit(), random_weighting(),
                random_weighting(), 3, 1'b0);
    held = write_weighting;
    repeat (12) begin
      @(negedge clk);
      check_value("ready after dropped start", 0, ready);
      check_value("held write_weighting", held, write_weighting);
    end
    report_test("start while busy");

    repeat (4) begin
      run_request(random_logit(), random_logit(), random_weighting(),
                  random_weighting(), 0, 1'b1);
    end
    report_test("input capture");

    $display("%0d tests, %0d requests, %0d checks, %0d errors",
             test_count, req_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
dnc_pkg.sv
logistic_if.sv
ntm_scalar_logistic_function.sv
dnc_write_gate.sv
dnc_allocation_gate.sv
dnc_write_weighting.sv
dnc_write_unit.sv
tb_dnc_write_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DNC write unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f \
  --top-module tb_dnc_write_unit -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
